// ==== cdcFifo.sv ====
// Dual-clock FIFO carrying any packed payload across domains with Gray pointers
`timescale 1ns/100ps
`include "ioCtrl_config.svh"

module cdcFifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `IOCTRL_FIFO_DEPTH
) (
    input  logic     rstN,
    input  logic     wrClk,
    input  logic     rdClk,
    input  logic     wrEn,
    input  payload_t wrData,
    output logic     notFull,
    input  logic     rdEn,
    output payload_t rdData,
    output logic     notEmpty
);
    // DEPTH is a power of two, at least 2
    localparam int ADDR_BITS = $clog2(DEPTH);

    typedef logic [ADDR_BITS:0] ptr_t;

    payload_t mem [DEPTH];

    ptr_t wrBin;
    ptr_t wrBinNext;
    ptr_t wrGray;
    ptr_t rdGraySync1;
    ptr_t rdGraySync2;
    ptr_t rdBinInWr;
    ptr_t rdBin;
    ptr_t rdBinNext;
    ptr_t rdGray;
    ptr_t wrGraySync1;
    ptr_t wrGraySync2;
    logic wrFire;
    logic rdFire;

    function automatic ptr_t bin2gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(ptr_t gray);
        ptr_t bin;
        bin[ADDR_BITS] = gray[ADDR_BITS];
        for (int i = ADDR_BITS - 1; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    // Write side
    assign rdBinInWr = gray2bin(rdGraySync2);
    // Full when only the wrap bit differs
    assign notFull = !((wrBin[ADDR_BITS] != rdBinInWr[ADDR_BITS]) &&
                       (wrBin[ADDR_BITS-1:0] == rdBinInWr[ADDR_BITS-1:0]));
    assign wrFire = wrEn && notFull;
    assign wrBinNext = wrBin + 1'b1;

    always_ff @(posedge wrClk or negedge rstN) begin
        if (!rstN) begin
            wrBin <= '0;
            wrGray <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end else begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
            if (wrFire) begin
                wrBin <= wrBinNext;
                wrGray <= bin2gray(wrBinNext);
            end
        end
    end

    always_ff @(posedge wrClk) begin
        if (wrFire) begin
            mem[wrBin[ADDR_BITS-1:0]] <= wrData;
        end
    end

    // Read side, head is visible without a read strobe
    assign notEmpty = (rdGray != wrGraySync2);
    assign rdFire = rdEn && notEmpty;
    assign rdBinNext = rdBin + 1'b1;
    assign rdData = mem[rdBin[ADDR_BITS-1:0]];

    always_ff @(posedge rdClk or negedge rstN) begin
        if (!rstN) begin
            rdBin <= '0;
            rdGray <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
        end else begin
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            if (rdFire) begin
                rdBin <= rdBinNext;
                rdGray <= bin2gray(rdBinNext);
            end
        end
    end

endmodule

// ==== ioCommandController.f ====
+incdir+.
ioCtrlPkg.sv
storeAssembler.sv
cdcFifo.sv
loadAligner.sv
ioCommandController.sv
ioCtrl_clkGen.sv
ioCtrl_checker.sv
ioCtrl_tb.sv

// ==== ioCommandController.sv ====
// IO command controller top: core command and writeback ports bridged to an IO port
`timescale 1ns/100ps

module ioCommandController (
    input  logic                 sys_clk,
    input  logic                 ioClk,
    input  logic                 rstN,
    input  logic                 cmdAck,
    output logic                 cmdReq,
    input  ioCtrlPkg::minorOp_t  minorOp,
    input  ioCtrlPkg::dataWord_t cmdOffset,
    input  ioCtrlPkg::dataWord_t cmdData,
    input  ioCtrlPkg::regIdx_t   cmdDestReg,
    output logic                 wbAck,
    input  logic                 wbReq,
    output ioCtrlPkg::regIdx_t   wbDestReg,
    output ioCtrlPkg::dataWord_t wbData,
    output logic                 ioCmdEn,
    input  logic                 ioCmdTake,
    output logic                 ioRespRequested,
    output ioCtrlPkg::regIdx_t   ioDestRegOut,
    output ioCtrlPkg::portWord_t ioDataOut,
    output logic                 ioReq,
    input  logic                 ioRegRespFlag,
    input  logic                 ioMemRespFlag,
    input  ioCtrlPkg::regIdx_t   ioDestRegIn,
    input  ioCtrlPkg::portWord_t ioDataIn
);
    import ioCtrlPkg::*;

    logic       push;
    logic       pushReady;
    logic       staleReq;
    cmdEntry_t  pushEntry;
    cmdEntry_t  cmdHead;
    logic       respWr;
    respEntry_t respWrEntry;
    logic       respValid;
    logic       respPop;
    respEntry_t respHead;

    storeAssembler assembler (
        .sys_clk   (sys_clk),
        .rstN      (rstN),
        .cmdAck    (cmdAck),
        .minorOp   (minorOp),
        .cmdOffset (cmdOffset),
        .cmdData   (cmdData),
        .cmdDestReg(cmdDestReg),
        .pushReady (pushReady),
        .staleReq  (staleReq),
        .cmdReq    (cmdReq),
        .push      (push),
        .pushEntry (pushEntry)
    );

    // Core to IO
    cdcFifo #(.payload_t(cmdEntry_t)) cmdCdc (
        .rstN    (rstN),
        .wrClk   (sys_clk),
        .rdClk   (ioClk),
        .wrEn    (push),
        .wrData  (pushEntry),
        .notFull (pushReady),
        .rdEn    (ioCmdTake),
        .rdData  (cmdHead),
        .notEmpty(ioCmdEn)
    );

    assign ioRespRequested = cmdHead.respRequested;
    assign ioDestRegOut = cmdHead.destReg;
    assign ioDataOut = cmdHead.data;

    // IO to core, either flag writes an entry
    assign respWr = ioRegRespFlag || ioMemRespFlag;
    assign respWrEntry = '{regFlag: ioRegRespFlag, destReg: ioDestRegIn, data: ioDataIn};

    cdcFifo #(.payload_t(respEntry_t)) respCdc (
        .rstN    (rstN),
        .wrClk   (ioClk),
        .rdClk   (sys_clk),
        .wrEn    (respWr),
        .wrData  (respWrEntry),
        .notFull (ioReq),
        .rdEn    (respPop),
        .rdData  (respHead),
        .notEmpty(respValid)
    );

    loadAligner aligner (
        .sys_clk   (sys_clk),
        .rstN      (rstN),
        .cmdAck    (cmdAck),
        .minorOp   (minorOp),
        .cmdOffset (cmdOffset),
        .cmdDestReg(cmdDestReg),
        .respValid (respValid),
        .respEntry (respHead),
        .respPop   (respPop),
        .staleReq  (staleReq),
        .wbAck     (wbAck),
        .wbReq     (wbReq),
        .wbDestReg (wbDestReg),
        .wbData    (wbData)
    );

endmodule

// ==== ioCtrlPkg.sv ====
// IO command controller types: opcode decode and payloads of both clock crossings
`include "ioCtrl_config.svh"

package ioCtrlPkg;

    localparam int PORT_BITS = `IOCTRL_PORT_BYTES * 8;
    localparam int SLICE_COUNT = (PORT_BITS > `IOCTRL_DATA_BITS) ?
                                 (PORT_BITS / `IOCTRL_DATA_BITS) : 1;
    localparam int SLICE_IDX_BITS = (SLICE_COUNT > 1) ? $clog2(SLICE_COUNT) : 1;

    typedef logic [`IOCTRL_DATA_BITS-1:0] dataWord_t;
    typedef logic [PORT_BITS-1:0]         portWord_t;
    typedef logic [3:0]                   regIdx_t;
    typedef logic [3:0]                   minorOp_t;
    typedef logic [SLICE_IDX_BITS-1:0]    sliceIdx_t;

    typedef enum logic [1:0] {
        STALE_LOAD,
        FRESH_LOAD,
        STORE
    } cmdKind_e;

    // Order matches opcode bits 1:0 of a stale load
    typedef enum logic [1:0] {
        FULL,
        LOW_BYTE,
        HIGH_BYTE,
        LOW_BYTE_SIGNED
    } loadSize_e;

    typedef struct packed {
        logic      respRequested;
        regIdx_t   destReg;
        portWord_t data;
    } cmdEntry_t;

    typedef struct packed {
        logic      regFlag;
        regIdx_t   destReg;
        portWord_t data;
    } respEntry_t;

    // Store wins over the load bits
    function automatic cmdKind_e decodeKind(minorOp_t op);
        cmdKind_e kind;
        if (op[2]) begin
            kind = STORE;
        end else if (op[3]) begin
            kind = FRESH_LOAD;
        end else begin
            kind = STALE_LOAD;
        end
        return kind;
    endfunction

endpackage

// ==== ioCtrl_checker.sv ====
// Bound assertions on the IO handshake and the reset state of the controller
`timescale 1ns/100ps

module ioCtrl_checker (
    input logic                 sys_clk,
    input logic                 ioClk,
    input logic                 rstN,
    input logic                 wbAck,
    input logic                 ioCmdEn,
    input logic                 ioCmdTake,
    input logic                 ioRespRequested,
    input ioCtrlPkg::regIdx_t   ioDestRegOut,
    input ioCtrlPkg::portWord_t ioDataOut
);
    // Nothing leaves the controller while held in reset
    assert property (@(posedge sys_clk) !rstN |-> !wbAck)
        else $error("wbAck high during reset");

    assert property (@(posedge ioClk) !rstN |-> !ioCmdEn)
        else $error("ioCmdEn high during reset");

    // Head must hold until the IO target takes it
    assert property (@(posedge ioClk) disable iff (!rstN)
        (ioCmdEn && !ioCmdTake) |=> (ioCmdEn && $stable(ioRespRequested)
            && $stable(ioDestRegOut) && $stable(ioDataOut)))
        else $error("IO command changed before it was taken");

endmodule

bind ioCommandController ioCtrl_checker checkerInst (
    .sys_clk        (sys_clk),
    .ioClk          (ioClk),
    .rstN           (rstN),
    .wbAck          (wbAck),
    .ioCmdEn        (ioCmdEn),
    .ioCmdTake      (ioCmdTake),
    .ioRespRequested(ioRespRequested),
    .ioDestRegOut   (ioDestRegOut),
    .ioDataOut      (ioDataOut)
);

// ==== ioCtrl_clkGen.sv ====
// Testbench clock and reset source for the core and IO clock domains
`timescale 1ns/100ps

module ioCtrl_clkGen (
    output logic sys_clk,
    output logic ioClk,
    output logic rstN
);
    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // IO side runs unrelated to the core clock
    initial begin
        ioClk = 1'b0;
        forever #17 ioClk = ~ioClk;
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        rstN = 1'b1;
    end

endmodule

// ==== ioCtrl_config.svh ====
// IO command controller sizing: port width, core data width and crossing depth
`ifndef IOCTRL_CONFIG_SVH
`define IOCTRL_CONFIG_SVH

// IO port width in bytes
`define IOCTRL_PORT_BYTES 4

// Core data word width in bits
`define IOCTRL_DATA_BITS 16

// Entries per clock crossing, power of two
`define IOCTRL_FIFO_DEPTH 8

`endif

// ==== ioCtrl_tb.sv ====
// Testbench for the IO command controller with an IO target model and reference checks
`timescale 1ns/100ps

module ioCtrl_tb;
    import ioCtrlPkg::*;

    localparam int NUM_CMDS = 48;
    localparam int DRAIN_LIMIT = 600;

    typedef struct packed {
        regIdx_t   destReg;
        dataWord_t data;
    } wbRec_t;

    logic sys_clk, ioClk, rstN;
    logic cmdAck, cmdReq, wbAck, wbReq, ioCmdEn, ioCmdTake, ioRespRequested, ioReq;
    logic ioRegRespFlag, ioMemRespFlag;
    minorOp_t  minorOp;
    dataWord_t cmdOffset, cmdData, wbData;
    regIdx_t   cmdDestReg, wbDestReg, ioDestRegOut, ioDestRegIn;
    portWord_t ioDataOut, ioDataIn;

    logic [31:0] lfsr = 32'd83733;
    cmdEntry_t expCmdQ[$], takenQ[$], pendingResp[$];
    wbRec_t    expWbQ[$], wbQ[$];
    portWord_t wordModel, refBuf, memWord;
    logic      memPending, ioStall, staleActive;

    ioCtrl_clkGen clkGen (.sys_clk(sys_clk), .ioClk(ioClk), .rstN(rstN));

    ioCommandController ioCommandController_inst (.*);

    task automatic stopRun();
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic failRun(string why);
        $display("%s", why);
        stopRun();
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic dataWord_t ioRef(portWord_t buffer, sliceIdx_t s, loadSize_e size);
        logic [15:0] sl;
        sl = s ? buffer[31:16] : buffer[15:0];
        case (size)
            LOW_BYTE:        return {8'h00, sl[7:0]};
            HIGH_BYTE:       return {8'h00, sl[15:8]};
            LOW_BYTE_SIGNED: return {{8{sl[7]}}, sl[7:0]};
            default:         return sl;
        endcase
    endfunction

    task automatic checkWord(string name, portWord_t got, portWord_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkCmd(cmdEntry_t got, cmdEntry_t exp);
        if (got.respRequested !== exp.respRequested || got.destReg !== exp.destReg) begin
            $display("CHECK FAILED ioRespRequested/ioDestRegOut got %h/%h expected %h/%h",
                     got.respRequested, got.destReg, exp.respRequested, exp.destReg);
            stopRun();
        end
        checkWord("ioDataOut", got.data, exp.data);
    endtask

    task automatic checkWb(regIdx_t gotReg, dataWord_t gotData, regIdx_t expReg,
                           dataWord_t expData);
        if (gotReg !== expReg || gotData !== expData) begin
            $display("CHECK FAILED wbDestReg/wbData got %h/%h expected %h/%h",
                     gotReg, gotData, expReg, expData);
            stopRun();
        end
    endtask

    // Drives one command from a falling edge and waits for cmdReq
    task automatic issueCmd(minorOp_t op, dataWord_t off, dataWord_t data, regIdx_t dest,
                            output regIdx_t gotReg, output dataWord_t gotData);
        int waited;
        logic done;
        waited = 0;
        done = 1'b0;
        cmdAck = 1'b1;
        minorOp = op;
        cmdOffset = off;
        cmdData = data;
        cmdDestReg = dest;
        staleActive = (op[3:2] == 2'b00);
        while (!done) begin
            #9;
            if (cmdReq) begin
                done = 1'b1;
                gotReg = wbDestReg;
                gotData = wbData;
                if (staleActive && !wbAck) failRun("stale load accepted without wbAck");
            end
            @(negedge sys_clk);
            waited++;
            if (!done && waited > DRAIN_LIMIT) failRun("command handshake timed out");
        end
        cmdAck = 1'b0;
        staleActive = 1'b0;
    endtask

    task automatic storeSlice(logic s, dataWord_t data, logic commit);
        regIdx_t r;
        dataWord_t d;
        regIdx_t dest;
        dest = regIdx_t'(randBits(4));
        if (s) wordModel[31:16] = data;
        else wordModel[15:0] = data;
        if (commit) expCmdQ.push_back('{1'b0, dest, wordModel});
        issueCmd(commit ? 4'b0110 : 4'b0100, {15'd0, s}, data, dest, r, d);
    endtask

    task automatic freshLoad(regIdx_t dest);
        regIdx_t r;
        dataWord_t d;
        portWord_t answer;
        answer = wordModel ^ 32'hA5A55A5A;
        expCmdQ.push_back('{1'b1, dest, wordModel});
        expWbQ.push_back('{dest, answer[15:0]});
        refBuf = answer;
        issueCmd(4'b1000, 16'd0, 16'd0, dest, r, d);
    endtask

    task automatic staleLoad(logic s, loadSize_e size, regIdx_t dest);
        regIdx_t r;
        dataWord_t d;
        issueCmd({2'b00, size}, {15'd0, s}, 16'hDEAD, dest, r, d);
        checkWb(r, d, dest, ioRef(refBuf, s, size));
    endtask

    task automatic drainQueues();
        int n;
        n = 0;
        while (expCmdQ.size() != 0 || expWbQ.size() != 0 || pendingResp.size() != 0
               || memPending) begin
            @(negedge sys_clk);
            n++;
            if (n > DRAIN_LIMIT) failRun("expected IO or writeback traffic never arrived");
        end
        // Lets late extras and the load buffer settle
        repeat (20) @(negedge sys_clk);
    endtask

    // IO target model
    initial begin : ioTarget
        cmdEntry_t taken;
        int takeDelay;
        int gap;
        takeDelay = 0;
        gap = 0;
        forever begin
            @(negedge ioClk);
            ioCmdTake = 1'b0;
            ioRegRespFlag = 1'b0;
            ioMemRespFlag = 1'b0;
            if (gap > 0) gap--;
            if (takeDelay > 0) takeDelay--;
            if (rstN && memPending && ioReq) begin
                ioMemRespFlag = 1'b1;
                ioDestRegIn = 4'h0;
                ioDataIn = memWord;
                memPending = 1'b0;
            end else if (rstN && pendingResp.size() > 0 && ioReq && gap == 0) begin
                taken = pendingResp.pop_front();
                ioRegRespFlag = 1'b1;
                ioDestRegIn = taken.destReg;
                ioDataIn = taken.data ^ 32'hA5A55A5A;
                gap = randBits(2);
            end else if (rstN && ioCmdEn && !ioStall && takeDelay == 0) begin
                ioCmdTake = 1'b1;
                taken = '{ioRespRequested, ioDestRegOut, ioDataOut};
                takenQ.push_back(taken);
                if (taken.respRequested) pendingResp.push_back(taken);
                takeDelay = randBits(2);
            end
        end
    end

    // Samples just ahead of each rising edge
    initial begin : wbMonitor
        forever begin
            @(negedge sys_clk);
            #9;
            if (rstN && wbAck && wbReq && !(staleActive && cmdReq)) begin
                wbQ.push_back('{wbDestReg, wbData});
            end
        end
    end

    initial begin : compare
        wbRec_t got, exp;
        forever begin
            @(negedge sys_clk);
            while (takenQ.size() > 0) begin
                if (expCmdQ.size() == 0) failRun("IO target received an unexpected command");
                checkCmd(takenQ.pop_front(), expCmdQ.pop_front());
            end
            while (wbQ.size() > 0) begin
                if (expWbQ.size() == 0) failRun("core received an unexpected writeback");
                got = wbQ.pop_front();
                exp = expWbQ.pop_front();
                checkWb(got.destReg, got.data, exp.destReg, exp.data);
            end
        end
    end

    initial begin : watchdog
        #(NUM_CMDS * 40 * 20 + 4000);
        $display("Watchdog expired before the tests finished");
        stopRun();
    end

    initial begin : stimulus
        logic [31:0] r1, r2;
        cmdAck = 1'b0;
        minorOp = '0;
        cmdOffset = '0;
        cmdData = '0;
        cmdDestReg = '0;
        wbReq = 1'b1;
        ioCmdTake = 1'b0;
        ioRegRespFlag = 1'b0;
        ioMemRespFlag = 1'b0;
        ioDestRegIn = '0;
        ioDataIn = '0;
        wordModel = '0;
        refBuf = '0;
        memWord = '0;
        memPending = 1'b0;
        ioStall = 1'b0;
        staleActive = 1'b0;

        wait (rstN);
        @(negedge sys_clk);
        if (wbAck || ioCmdEn || !ioReq) failRun("wrong idle outputs after reset");
        staleLoad(1'b0, FULL, 4'h1);
        staleLoad(1'b1, FULL, 4'h2);

        // Random slices then one commit
        for (int i = 0; i < 3; i++) begin
            r1 = randBits(1);
            r2 = randBits(16);
            storeSlice(r1[0], r2[15:0], 1'b0);
        end
        r2 = randBits(16);
        storeSlice(1'b1, r2[15:0], 1'b1);
        drainQueues();

        // Commits pile up behind a stalled target
        ioStall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            r2 = randBits(16);
            storeSlice(i[0], r2[15:0], 1'b1);
        end
        repeat (10) @(negedge sys_clk);
        ioStall = 1'b0;
        drainQueues();

        for (int i = 0; i < 3; i++) begin
            r2 = randBits(16);
            storeSlice(1'b0, r2[15:0], 1'b0);
            freshLoad(regIdx_t'(i + 3));
        end
        drainQueues();
        staleLoad(1'b0, FULL, 4'h7);

        // Memory response only touches the load buffer
        r1 = randBits(32);
        memWord = r1;
        refBuf = r1;
        memPending = 1'b1;
        drainQueues();
        for (int s = 0; s < 2; s++) begin
            for (int z = 0; z < 4; z++) begin
                staleLoad(s[0], loadSize_e'(z), regIdx_t'(z + 8));
            end
        end

        // Writebacks held off by the core
        wbReq = 1'b0;
        for (int i = 0; i < 3; i++) freshLoad(regIdx_t'(i + 12));
        repeat (60) @(negedge sys_clk);
        minorOp = 4'b0000;
        wbReq = 1'b1;
        #9;
        if (cmdReq) failRun("stale load ready while register writebacks pending");
        @(negedge sys_clk);
        drainQueues();

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== loadAligner.sv ====
// Load aligner: holds the load buffer, drains responses, arbitrates core writebacks
`timescale 1ns/100ps

module loadAligner (
    input  logic                  sys_clk,
    input  logic                  rstN,
    input  logic                  cmdAck,
    input  ioCtrlPkg::minorOp_t   minorOp,
    input  ioCtrlPkg::dataWord_t  cmdOffset,
    input  ioCtrlPkg::regIdx_t    cmdDestReg,
    input  logic                  respValid,
    input  ioCtrlPkg::respEntry_t respEntry,
    output logic                  respPop,
    output logic                  staleReq,
    output logic                  wbAck,
    input  logic                  wbReq,
    output ioCtrlPkg::regIdx_t    wbDestReg,
    output ioCtrlPkg::dataWord_t  wbData
);
    import ioCtrlPkg::*;

    localparam int SLICE_BITS = $bits(dataWord_t);

    logic      isStale;
    logic      regPending;
    loadSize_e loadSize;
    sliceIdx_t sliceSel;
    portWord_t loadBuf;
    dataWord_t slice;
    dataWord_t alignedData;

    assign isStale = (decodeKind(minorOp) == STALE_LOAD);
    assign loadSize = loadSize_e'(minorOp[1:0]);
    assign sliceSel = cmdOffset[$bits(sliceIdx_t)-1:0];

    // Register response at the head owns the writeback port
    assign regPending = respValid && respEntry.regFlag;
    assign staleReq = wbReq && !regPending;

    // Memory responses leave at once, register ones wait for the core
    assign respPop = respValid && (!respEntry.regFlag || wbReq);

    assign slice = loadBuf[sliceSel * SLICE_BITS +: SLICE_BITS];

    always_comb begin
        case (loadSize)
            FULL:            alignedData = slice;
            LOW_BYTE:        alignedData = dataWord_t'(slice[7:0]);
            HIGH_BYTE:       alignedData = dataWord_t'(slice[15:8]);
            LOW_BYTE_SIGNED: alignedData = {{(SLICE_BITS - 8){slice[7]}}, slice[7:0]};
        endcase
    end

    assign wbAck = regPending || (cmdAck && isStale);
    assign wbDestReg = regPending ? respEntry.destReg : cmdDestReg;
    assign wbData = regPending ? respEntry.data[SLICE_BITS-1:0] : alignedData;

    // Whole port word is kept, both response kinds refresh it
    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            loadBuf <= '0;
        end else if (respPop) begin
            loadBuf <= respEntry.data;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f ioCommandController.f --top-module ioCtrl_tb -o ioCtrlSim \
    && ./obj_dir/ioCtrlSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation FAILED"; exit 1; }

cat sim.log
grep -q "^Everything OK$" sim.log && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

// ==== storeAssembler.sv ====
// Store assembler: decodes core commands, merges store slices, pushes IO commands
`timescale 1ns/100ps

module storeAssembler (
    input  logic                 sys_clk,
    input  logic                 rstN,
    input  logic                 cmdAck,
    input  ioCtrlPkg::minorOp_t  minorOp,
    input  ioCtrlPkg::dataWord_t cmdOffset,
    input  ioCtrlPkg::dataWord_t cmdData,
    input  ioCtrlPkg::regIdx_t   cmdDestReg,
    input  logic                 pushReady,
    input  logic                 staleReq,
    output logic                 cmdReq,
    output logic                 push,
    output ioCtrlPkg::cmdEntry_t pushEntry
);
    import ioCtrlPkg::*;

    localparam int SLICE_BITS = $bits(dataWord_t);

    cmdKind_e  kind;
    logic      isCommit;
    logic      needsPush;
    logic      storeTaken;
    sliceIdx_t sliceSel;
    portWord_t heldWord;
    portWord_t mergedWord;

    assign kind = decodeKind(minorOp);

    // Commit bit only counts for stores
    assign isCommit = (kind == STORE) && minorOp[1];
    assign needsPush = isCommit || (kind == FRESH_LOAD);
    assign sliceSel = cmdOffset[$bits(sliceIdx_t)-1:0];

    always_comb begin
        mergedWord = heldWord;
        mergedWord[sliceSel * SLICE_BITS +: SLICE_BITS] = cmdData;
    end

    // Ready depends on where the command goes
    always_comb begin
        case (kind)
            STALE_LOAD: cmdReq = staleReq;
            FRESH_LOAD: cmdReq = pushReady;
            default:    cmdReq = isCommit ? pushReady : 1'b1;
        endcase
    end

    assign push = cmdAck && pushReady && needsPush;
    assign storeTaken = cmdAck && cmdReq && (kind == STORE);

    always_comb begin
        pushEntry.respRequested = (kind == FRESH_LOAD);
        pushEntry.destReg = cmdDestReg;
        // Commit carries the slice being written this cycle
        pushEntry.data = (kind == STORE) ? mergedWord : heldWord;
    end

    // Word survives a push so later stores can patch single slices
    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            heldWord <= '0;
        end else if (storeTaken) begin
            heldWord <= mergedWord;
        end
    end

endmodule
